// File: include/lsu_macros.svh
// sizing macros for the load/store unit, included by the packages and sized rtl blocks.
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// width of a data word and of an address in bits.
`define LSU_XLEN 32

// number of architectural integer registers.
`define LSU_REG_COUNT 32

// data ram depth in words, byte limit is four times this.
`define LSU_RAM_WORDS 256

`endif

// File: rtl/core_pkg.sv
// core-side types shared by the memory access, retire and register bank blocks.
`include "lsu_macros.svh"

package core_pkg;

    // one data or address word.
    typedef logic [`LSU_XLEN-1:0] word_t;

    // index into the register bank.
    typedef logic [$clog2(`LSU_REG_COUNT)-1:0] reg_idx_t;

    // operations that reach the memory stage.
    typedef enum logic [3:0] {
        NOP,    // nothing to retire.
        ALU,    // result already computed by execute.
        LB,     // signed byte load.
        LBU,    // unsigned byte load.
        LH,     // signed halfword load.
        LHU,    // unsigned halfword load.
        LW,     // word load.
        SB,     // byte store.
        SH,     // halfword store.
        SW      // word store.
    } iType_e;

endpackage

// File: rtl/apb_pkg.sv
// apb bus types used between the memory access master and the data ram slave.
`include "lsu_macros.svh"

package apb_pkg;

    // byte address on the bus.
    typedef logic [`LSU_XLEN-1:0] paddr_t;

    // one strobe bit per byte lane.
    typedef logic [`LSU_XLEN/8-1:0] strb_t;

    // master side transfer phases.
    typedef enum logic [1:0] {
        IDLE,   // no transfer.
        SETUP,  // psel up, penable low.
        ACCESS  // penable up, wait for pready.
    } apb_state_e;

endpackage

// File: rtl/data_ram.sv
// word-wide apb slave ram with byte strobes, used as the data memory of the lsu.
`include "lsu_macros.svh"

module data_ram (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  apb_pkg::paddr_t    paddr_i,
    input  core_pkg::word_t    pwdata_i,
    input  apb_pkg::strb_t     pstrb_i,
    output core_pkg::word_t    prdata_o,
    output logic               pready_o,
    output logic               pslverr_o
);

    localparam int unsigned AW = $clog2(`LSU_RAM_WORDS); // word index width.

    core_pkg::word_t   mem [`LSU_RAM_WORDS];  // storage, no reset.
    logic [AW-1:0]     word_idx;
    logic              in_range;
    logic              access;
    logic              wr_en;

    assign word_idx = paddr_i[AW+1:2];                       // bits 1:0 are ignored.
    assign in_range = (paddr_i < apb_pkg::paddr_t'(`LSU_RAM_WORDS * 4));
    assign access   = psel_i && penable_i;                   // access phase of a transfer.

    // no writes while the bus is held in reset.
    assign wr_en = access && pwrite_i && in_range && arst_n_i;

    // zero wait states, answer in the first access cycle.
    assign pready_o  = access;
    assign pslverr_o = access && !in_range;                  // out of range gives an error.
    assign prdata_o  = in_range ? mem[word_idx] : '0;

    // byte-lane write, only strobed lanes change.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < `LSU_XLEN/8; b++) begin
                if (pstrb_i[b]) begin
                    mem[word_idx][b*8 +: 8] <= pwdata_i[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: rtl/mem_access.sv
// memory stage front end, takes finished ops from execute and runs apb transfers for loads and stores.
module mem_access (
    input  logic                 clk,
    input  logic                 arst_n_i,
    // command channel from execute.
    input  logic                 cmd_valid_i,
    output logic                 cmd_ready_o,
    input  core_pkg::iType_e     cmd_op_i,
    input  core_pkg::word_t      cmd_result_i,
    input  core_pkg::word_t      cmd_wdata_i,
    input  core_pkg::reg_idx_t   cmd_rd_i,
    input  logic                 cmd_we_i,
    // apb master.
    output logic                 psel_o,
    output logic                 penable_o,
    output logic                 pwrite_o,
    output apb_pkg::paddr_t      paddr_o,
    output core_pkg::word_t      pwdata_o,
    output apb_pkg::strb_t       pstrb_o,
    input  core_pkg::word_t      prdata_i,
    input  logic                 pready_i,
    input  logic                 pslverr_i,
    // toward retire and the register bank.
    output core_pkg::iType_e     ret_op_o,
    output core_pkg::word_t      ret_result_o,
    output core_pkg::word_t      ret_mem_data_o,
    output logic                 ret_we_o,
    output core_pkg::reg_idx_t   rf_waddr_o,
    output logic                 err_o
);

    apb_pkg::apb_state_e  state_q, state_d;
    core_pkg::iType_e     op_q;       // registered operation.
    core_pkg::word_t      result_q;   // result or effective address.
    core_pkg::word_t      wdata_q;    // raw store data.
    core_pkg::reg_idx_t   rd_q;       // destination register.
    logic                 we_q;       // destination write requested.
    logic                 alu_vld_q;  // alu op waiting to retire.
    logic                 accept;
    logic                 is_mem_cmd;
    logic                 is_load_q;
    logic                 is_store_q;
    logic                 xfer_done;
    core_pkg::word_t      lane_data;
    apb_pkg::strb_t       lane_strb;

    assign is_mem_cmd = cmd_op_i inside {core_pkg::LB, core_pkg::LBU, core_pkg::LH,
                                         core_pkg::LHU, core_pkg::LW, core_pkg::SB,
                                         core_pkg::SH, core_pkg::SW};
    assign is_load_q  = op_q inside {core_pkg::LB, core_pkg::LBU, core_pkg::LH,
                                     core_pkg::LHU, core_pkg::LW};
    assign is_store_q = op_q inside {core_pkg::SB, core_pkg::SH, core_pkg::SW};

    assign xfer_done   = (state_q == apb_pkg::ACCESS) && pready_i;  // completion edge next.
    assign cmd_ready_o = (state_q == apb_pkg::IDLE) || xfer_done;   // take work at completion.
    assign accept      = cmd_valid_i && cmd_ready_o;

    // apb master fsm, one setup cycle then access until pready.
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            apb_pkg::IDLE:   if (accept && is_mem_cmd) state_d = apb_pkg::SETUP;
            apb_pkg::SETUP:  state_d = apb_pkg::ACCESS;
            apb_pkg::ACCESS: begin
                if (pready_i) begin
                    state_d = (accept && is_mem_cmd) ? apb_pkg::SETUP : apb_pkg::IDLE;
                end
            end
            default:         state_d = apb_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= apb_pkg::IDLE;
            alu_vld_q <= 1'b0;
            err_o     <= 1'b0;
        end else begin
            state_q   <= state_d;
            alu_vld_q <= accept && (cmd_op_i == core_pkg::ALU);  // retires next cycle.
            err_o     <= xfer_done && pslverr_i;                 // one-cycle error pulse.
        end
    end

    // command payload, captured on every handshake.
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q     <= cmd_op_i;
            result_q <= cmd_result_i;
            wdata_q  <= cmd_wdata_i;
            rd_q     <= cmd_rd_i;
            we_q     <= cmd_we_i;
        end
    end

    // store lane placement, data replicated and strobes pick the lanes.
    always_comb begin
        lane_data = wdata_q;
        lane_strb = '0;                                    // loads carry no strobes.
        case (op_q)
            core_pkg::SB: begin
                lane_data = {4{wdata_q[7:0]}};
                lane_strb = apb_pkg::strb_t'(4'b0001 << result_q[1:0]);
            end
            core_pkg::SH: begin
                lane_data = {2{wdata_q[15:0]}};
                lane_strb = result_q[1] ? 4'b1100 : 4'b0011;  // same lane rule as retire.
            end
            core_pkg::SW: lane_strb = '1;
            default: ;
        endcase
    end

    assign psel_o    = (state_q != apb_pkg::IDLE);
    assign penable_o = (state_q == apb_pkg::ACCESS);
    assign pwrite_o  = is_store_q;
    assign paddr_o   = result_q;
    assign pwdata_o  = lane_data;
    assign pstrb_o   = lane_strb;

    // a failed transfer is killed and never writes back.
    assign ret_we_o       = we_q && (alu_vld_q || (xfer_done && !pslverr_i && is_load_q));
    assign ret_op_o       = op_q;
    assign ret_result_o   = result_q;
    assign ret_mem_data_o = prdata_i;                      // load path is combinational.
    assign rf_waddr_o     = rd_q;

endmodule

// File: rtl/retire.sv
// writeback selection, extends load data and picks what goes into the register bank.
module retire (
    input  logic               write_enable_i,
    input  core_pkg::iType_e   instruction_operation_i,
    input  core_pkg::word_t    result_i,
    input  core_pkg::word_t    mem_data_i,
    output logic               regbank_write_enable_o,
    output core_pkg::word_t    regbank_data_o
);

    logic [7:0]        sel_byte;     // addressed byte lane.
    logic [15:0]       sel_half;     // addressed halfword lane.
    logic              is_signed;    // sign extension wanted.
    logic              is_load;
    core_pkg::word_t   memory_data;  // extended load value.

    // byte lane from address bits 1:0.
    always_comb begin
        case (result_i[1:0])
            2'b11:   sel_byte = mem_data_i[31:24];
            2'b10:   sel_byte = mem_data_i[23:16];
            2'b01:   sel_byte = mem_data_i[15:8];
            default: sel_byte = mem_data_i[7:0];
        endcase
    end

    // halfword lane only looks at bit 1.
    assign sel_half = result_i[1] ? mem_data_i[31:16] : mem_data_i[15:0];

    assign is_signed = (instruction_operation_i == core_pkg::LB) ||
                       (instruction_operation_i == core_pkg::LH);

    always_comb begin
        unique case (instruction_operation_i)
            core_pkg::LB, core_pkg::LBU: begin
                memory_data = {{24{is_signed && sel_byte[7]}}, sel_byte};   // byte extend.
            end
            core_pkg::LH, core_pkg::LHU: begin
                memory_data = {{16{is_signed && sel_half[15]}}, sel_half};  // half extend.
            end
            default: memory_data = mem_data_i;  // full word.
        endcase
    end

    assign is_load = instruction_operation_i inside {core_pkg::LB, core_pkg::LBU, core_pkg::LH,
                                                     core_pkg::LHU, core_pkg::LW};

    // loads write memory data, everything else the result.
    assign regbank_data_o = is_load ? memory_data : result_i;

    // kill decision was already made upstream.
    assign regbank_write_enable_o = write_enable_i;

endmodule

// File: rtl/reg_bank.sv
// integer register bank with one write port and a combinational debug read port.
`include "lsu_macros.svh"

module reg_bank (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 we_i,
    input  core_pkg::reg_idx_t   waddr_i,
    input  core_pkg::word_t      wdata_i,
    input  core_pkg::reg_idx_t   raddr_i,
    output core_pkg::word_t      rdata_o
);

    core_pkg::word_t   regs [`LSU_REG_COUNT];  // architectural registers.
    logic              wr_ok;

    // x0 is never written.
    assign wr_ok = we_i && (waddr_i != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `LSU_REG_COUNT; i++) begin
                regs[i] <= '0;                     // whole bank cleared.
            end
        end else if (wr_ok) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 stays zero since it is cleared on reset and skipped by writes.
    assign rdata_o = regs[raddr_i];

endmodule

// File: rtl/lsu_top.sv
// top of the memory and writeback end, ties command input, apb ram, retire and registers.
module lsu_top (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 cmd_valid_i,
    output logic                 cmd_ready_o,
    input  core_pkg::iType_e     cmd_op_i,
    input  core_pkg::word_t      cmd_result_i,
    input  core_pkg::word_t      cmd_wdata_i,
    input  core_pkg::reg_idx_t   cmd_rd_i,
    input  logic                 cmd_we_i,
    input  core_pkg::reg_idx_t   rf_raddr_i,
    output core_pkg::word_t      rf_rdata_o,
    output logic                 err_o
);

    // apb bus.
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    apb_pkg::paddr_t      paddr;
    core_pkg::word_t      pwdata;
    apb_pkg::strb_t       pstrb;
    core_pkg::word_t      prdata;
    logic                 pready;
    logic                 pslverr;
    // retire side.
    core_pkg::iType_e     ret_op;
    core_pkg::word_t      ret_result;
    core_pkg::word_t      ret_mem_data;
    logic                 ret_we;
    core_pkg::reg_idx_t   rf_waddr;
    // register write port.
    logic                 rf_we;
    core_pkg::word_t      rf_wdata;

    mem_access u_mem_access (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_ready_o    (cmd_ready_o),
        .cmd_op_i       (cmd_op_i),
        .cmd_result_i   (cmd_result_i),
        .cmd_wdata_i    (cmd_wdata_i),
        .cmd_rd_i       (cmd_rd_i),
        .cmd_we_i       (cmd_we_i),
        .psel_o         (psel),
        .penable_o      (penable),
        .pwrite_o       (pwrite),
        .paddr_o        (paddr),
        .pwdata_o       (pwdata),
        .pstrb_o        (pstrb),
        .prdata_i       (prdata),
        .pready_i       (pready),
        .pslverr_i      (pslverr),
        .ret_op_o       (ret_op),
        .ret_result_o   (ret_result),
        .ret_mem_data_o (ret_mem_data),
        .ret_we_o       (ret_we),
        .rf_waddr_o     (rf_waddr),
        .err_o          (err_o)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .pstrb_i   (pstrb),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    retire u_retire (
        .write_enable_i          (ret_we),
        .instruction_operation_i (ret_op),
        .result_i                (ret_result),
        .mem_data_i              (ret_mem_data),
        .regbank_write_enable_o  (rf_we),
        .regbank_data_o          (rf_wdata)
    );

    reg_bank u_reg_bank (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),   // index comes straight from mem_access.
        .wdata_i  (rf_wdata),
        .raddr_i  (rf_raddr_i),
        .rdata_o  (rf_rdata_o)
    );

endmodule

// File: verif/tb_lsu_top.sv
// directed testbench for lsu_top, run it as the simulation top against the rtl in sources.f.
`include "lsu_macros.svh"

module tb_lsu_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RAM_BYTES = `LSU_RAM_WORDS * 4;  // byte address limit.
    localparam int ALU_N     = 12;                  // alu writes in the first test.
    localparam int HOLD_N    = 4;                   // alu ops with the write enable low.
    localparam int SW_N      = 8;                   // word store/load pairs.
    localparam int EXT_WORDS = 2;                   // words probed by the narrow loads.
    // commands plus register readbacks over all tests.
    localparam int CMD_COUNT = (2 * ALU_N + 2 + 2 * HOLD_N) + 3 * SW_N + EXT_WORDS * 33
                               + 32 + 12;
    localparam int TIMEOUT_CYCLES = 4 * CMD_COUNT + 200;

    logic                clk;
    logic                arst_n_i;
    logic                cmd_valid_i;
    logic                cmd_ready_o;
    core_pkg::iType_e    cmd_op_i;
    core_pkg::word_t     cmd_result_i;
    core_pkg::word_t     cmd_wdata_i;
    core_pkg::reg_idx_t  cmd_rd_i;
    logic                cmd_we_i;
    core_pkg::reg_idx_t  rf_raddr_i;
    core_pkg::word_t     rf_rdata_o;
    logic                err_o;

    logic [7:0]          ram_model [RAM_BYTES];        // byte image of the data ram.
    core_pkg::word_t     reg_model [`LSU_REG_COUNT];   // expected register contents.
    logic [31:0]         rng_state = 32'hc0bc;
    int                  checks = 0;
    int                  errors = 0;
    int                  cycles = 0;

    lsu_top u_lsu_top (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_ready_o  (cmd_ready_o),
        .cmd_op_i     (cmd_op_i),
        .cmd_result_i (cmd_result_i),
        .cmd_wdata_i  (cmd_wdata_i),
        .cmd_rd_i     (cmd_rd_i),
        .cmd_we_i     (cmd_we_i),
        .rf_raddr_i   (rf_raddr_i),
        .rf_rdata_o   (rf_rdata_o),
        .err_o        (err_o)
    );

    always #10 clk = ~clk;  // 20 ns period.

    // run limit, a hung handshake ends here.
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: no end of run after %0d cycles, a handshake never came", cycles);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;  // xorshift32.
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic core_pkg::reg_idx_t rand_rd();
        return core_pkg::reg_idx_t'(1 + next_rand() % 31);  // never x0.
    endfunction

    function automatic core_pkg::word_t rand_addr();
        logic [31:0] r;
        r = next_rand();
        return {22'd0, r[9:2], 2'b00};  // aligned, inside the ram.
    endfunction

    // expected load value, the ram ignores bits 1:0 and lanes follow the low bits.
    function automatic core_pkg::word_t model_load(input core_pkg::iType_e op,
                                                   input core_pkg::word_t addr);
        logic [9:0]  wbase;
        logic [9:0]  hbase;
        logic [7:0]  b;
        logic [15:0] h;
        core_pkg::word_t w;
        wbase = {addr[9:2], 2'b00};
        hbase = {addr[9:2], addr[1], 1'b0};  // halfword lane from bit 1 only.
        b = ram_model[addr[9:0]];
        h = {ram_model[hbase + 1], ram_model[hbase]};
        w = {ram_model[wbase + 3], ram_model[wbase + 2], ram_model[wbase + 1], ram_model[wbase]};
        case (op)
            core_pkg::LB:  return {{24{b[7]}}, b};
            core_pkg::LBU: return {24'd0, b};
            core_pkg::LH:  return {{16{h[15]}}, h};
            core_pkg::LHU: return {16'd0, h};
            default:       return w;
        endcase
    endfunction

    function automatic void model_store(input core_pkg::iType_e op, input core_pkg::word_t addr,
                                        input core_pkg::word_t data);
        logic [9:0] wbase;
        logic [9:0] hbase;
        wbase = {addr[9:2], 2'b00};
        hbase = {addr[9:2], addr[1], 1'b0};
        case (op)
            core_pkg::SB: ram_model[addr[9:0]] = data[7:0];
            core_pkg::SH: begin
                ram_model[hbase]     = data[7:0];
                ram_model[hbase + 1] = data[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) ram_model[wbase + i] = data[i*8 +: 8];
            end
        endcase
    endfunction

    task automatic check_word(input string name, input core_pkg::word_t got,
                              input core_pkg::word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // debug port readback, sampled mid-cycle.
    task automatic check_reg(input core_pkg::reg_idx_t idx);
        @(posedge clk);
        rf_raddr_i <= idx;
        @(negedge clk);
        check_word($sformatf("rf_rdata_o[x%0d]", idx), rf_rdata_o, reg_model[idx]);
    endtask

    // one command through the handshake, then wait for completion and check err_o.
    task automatic exec_cmd(input core_pkg::iType_e op, input core_pkg::word_t res,
                            input core_pkg::word_t wdata, input core_pkg::reg_idx_t rd,
                            input logic we);
        logic is_load;
        logic is_store;
        logic exp_err;
        is_load  = op inside {core_pkg::LB, core_pkg::LBU, core_pkg::LH, core_pkg::LHU,
                              core_pkg::LW};
        is_store = op inside {core_pkg::SB, core_pkg::SH, core_pkg::SW};
        exp_err  = (is_load || is_store) && (res >= RAM_BYTES);
        @(posedge clk);
        cmd_valid_i  <= 1'b1;
        cmd_op_i     <= op;
        cmd_result_i <= res;
        cmd_wdata_i  <= wdata;
        cmd_rd_i     <= rd;
        cmd_we_i     <= we;
        @(negedge clk);
        while (!cmd_ready_o) @(negedge clk);  // handshake at the next edge.
        @(posedge clk);
        cmd_valid_i <= 1'b0;
        @(negedge clk);
        while (!cmd_ready_o) @(negedge clk);  // low while a transfer runs.
        @(posedge clk);                        // completion edge.
        @(negedge clk);
        check_flag("err_o", err_o, exp_err);
        // a killed op leaves both models alone.
        if (!exp_err && we && rd != 0 && is_load) reg_model[rd] = model_load(op, res);
        if (we && rd != 0 && op == core_pkg::ALU) reg_model[rd] = res;
        if (!exp_err && is_store) model_store(op, res, wdata);
    endtask

    task automatic run_alu_ops();
        core_pkg::reg_idx_t rd;
        for (int i = 0; i < ALU_N; i++) begin
            rd = rand_rd();
            exec_cmd(core_pkg::ALU, next_rand(), '0, rd, 1'b1);
            check_reg(rd);
        end
        exec_cmd(core_pkg::ALU, 32'hdead_beef, '0, '0, 1'b1);  // x0 stays zero.
        check_reg('0);
        for (int i = 0; i < HOLD_N; i++) begin
            rd = rand_rd();
            exec_cmd(core_pkg::ALU, next_rand(), '0, rd, 1'b0);  // no write expected.
            check_reg(rd);
        end
    endtask

    task automatic sw_lw_roundtrip();
        core_pkg::word_t addr [SW_N];
        core_pkg::reg_idx_t rd;
        for (int i = 0; i < SW_N; i++) begin
            addr[i] = rand_addr();
            exec_cmd(core_pkg::SW, addr[i], next_rand(), '0, 1'b0);
        end
        for (int i = 0; i < SW_N; i++) begin
            rd = rand_rd();
            exec_cmd(core_pkg::LW, addr[i], '0, rd, 1'b1);
            check_reg(rd);
        end
    endtask

    task automatic narrow_load_ext();
        core_pkg::word_t    base;
        core_pkg::word_t    data;
        core_pkg::reg_idx_t rd;
        core_pkg::iType_e   ops [4];
        ops = '{core_pkg::LB, core_pkg::LBU, core_pkg::LH, core_pkg::LHU};
        for (int w = 0; w < EXT_WORDS; w++) begin
            base = rand_addr();
            data = next_rand();
            data = (w == 0) ? (data & 32'h7f7f_7f7f) : (data | 32'h8080_8080);  // both signs.
            exec_cmd(core_pkg::SW, base, data, '0, 1'b0);
            for (int off = 0; off < 4; off++) begin
                foreach (ops[k]) begin
                    rd = rand_rd();
                    exec_cmd(ops[k], base + off, '0, rd, 1'b1);
                    check_reg(rd);
                end
            end
        end
    endtask

    task automatic narrow_store_lanes();
        core_pkg::word_t    base;
        core_pkg::reg_idx_t rd;
        for (int off = 0; off < 4; off++) begin
            base = rand_addr();
            exec_cmd(core_pkg::SW, base, next_rand(), '0, 1'b0);
            exec_cmd(core_pkg::SB, base + off, next_rand(), '0, 1'b0);
            rd = rand_rd();
            exec_cmd(core_pkg::LW, base, '0, rd, 1'b1);  // other bytes untouched.
            check_reg(rd);
            exec_cmd(core_pkg::SW, base, next_rand(), '0, 1'b0);
            exec_cmd(core_pkg::SH, base + off, next_rand(), '0, 1'b0);
            rd = rand_rd();
            exec_cmd(core_pkg::LW, base, '0, rd, 1'b1);
            check_reg(rd);
        end
    endtask

    task automatic out_of_range_kill();
        core_pkg::word_t    addr;
        core_pkg::reg_idx_t rd;
        rd = 5'd7;
        exec_cmd(core_pkg::ALU, 32'h1234_5678, '0, rd, 1'b1);
        exec_cmd(core_pkg::LW, RAM_BYTES + 8, '0, rd, 1'b1);       // killed load.
        exec_cmd(core_pkg::LB, 32'hffff_fff1, '0, rd, 1'b1);
        check_reg(rd);
        addr = rand_addr();
        exec_cmd(core_pkg::SW, addr, 32'h0bad_cafe, '0, 1'b0);
        exec_cmd(core_pkg::SW, addr + RAM_BYTES, 32'h5555_aaaa, '0, 1'b0);  // same index, killed.
        exec_cmd(core_pkg::LW, addr, '0, rd, 1'b1);                // next op runs normally.
        check_reg(rd);
        exec_cmd(core_pkg::ALU, 32'h0000_0042, '0, 5'd9, 1'b1);
        check_reg(5'd9);
    endtask

    initial begin
        clk          = 1'b0;
        arst_n_i     = 1'b0;
        cmd_valid_i  = 1'b0;
        cmd_op_i     = core_pkg::NOP;
        cmd_result_i = '0;
        cmd_wdata_i  = '0;
        cmd_rd_i     = '0;
        cmd_we_i     = 1'b0;
        rf_raddr_i   = '0;
        foreach (reg_model[i]) reg_model[i] = '0;  // bank clears on reset.
        repeat (2) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        check_flag("cmd_ready_o", cmd_ready_o, 1'b1);
        check_flag("err_o", err_o, 1'b0);
        run_alu_ops();
        sw_lw_roundtrip();
        narrow_load_ext();
        narrow_store_lanes();
        out_of_range_kill();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
rtl/core_pkg.sv
rtl/apb_pkg.sv
rtl/data_ram.sv
rtl/mem_access.sv
rtl/retire.sv
rtl/reg_bank.sv
rtl/lsu_top.sv
verif/tb_lsu_top.sv

// File: Bender.yml
package:
  name: lsu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/core_pkg.sv
      - rtl/apb_pkg.sv
      - rtl/data_ram.sv
      - rtl/mem_access.sv
      - rtl/retire.sv
      - rtl/reg_bank.sv
      - rtl/lsu_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_lsu_top.sv
